//--- build.f
verilog/adt_cfg_pkg.sv
verilog/adt_access_pkg.sv
verilog/access_granule_decode.sv
verilog/dep_entry_queue.sv
verilog/alias_match_port.sv
verilog/address_dependency_table.sv
sim/adt_checker.sv
sim/adt_tb.sv

//--- sim/adt_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top: clock, reset, stimulus table
// applied row by row, and the run timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module adt_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clk_period   = 100;
   localparam int reset_cycles = 8;
   localparam int num_rows     = 24;
   localparam int cycle_limit  = num_rows + reset_cycles + 20;

   typedef struct packed {
      logic [8*16-1:0]            name;
      logic [2:0]                 strobes;    // push, pop, flush
      adt_access_pkg::addr_t      push_addr;
      adt_access_pkg::size_code_t push_size;
      adt_access_pkg::addr_t      cmp0_addr;
      adt_access_pkg::size_code_t cmp0_size;
      adt_access_pkg::addr_t      cmp1_addr;
      adt_access_pkg::size_code_t cmp1_size;
      logic [1:0]                 exp_hits;   // port 0, port 1
   } row_t;

   row_t rows [num_rows];
   int   row_cnt   = 0;
   int   cycle_cnt = 0;

   logic                       clk = 1'b0;
   logic                       rst_n;
   logic                       flush;
   logic                       push;
   logic                       pop;
   adt_access_pkg::addr_t      push_addr;
   adt_access_pkg::size_code_t push_size;
   adt_access_pkg::addr_t      cmp0_addr;
   adt_access_pkg::size_code_t cmp0_size;
   adt_access_pkg::addr_t      cmp1_addr;
   adt_access_pkg::size_code_t cmp1_size;
   logic                       hit0;
   logic                       hit1;

   logic                       check;
   logic [31:0]                check_idx;
   logic [8*16-1:0]            check_name;
   logic [1:0]                 check_exp;
   int                         checked_cnt;
   int                         error_cnt;

   address_dependency_table dut_i (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .flush_i     (flush),
      .push_i      (push),
      .pop_i       (pop),
      .push_addr_i (push_addr),
      .push_size_i (push_size),
      .cmp0_addr_i (cmp0_addr),
      .cmp0_size_i (cmp0_size),
      .cmp1_addr_i (cmp1_addr),
      .cmp1_size_i (cmp1_size),
      .cmp0_hit_o  (hit0),
      .cmp1_hit_o  (hit1)
   );

   adt_checker chk_i (
      .clk           (clk),
      .check_i       (check),
      .row_idx_i     (check_idx),
      .row_name_i    (check_name),
      .exp_hits_i    (check_exp),
      .hit0_i        (hit0),
      .hit1_i        (hit1),
      .checked_cnt_o (checked_cnt),
      .error_cnt_o   (error_cnt)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic set_row(input logic [8*16-1:0] name, input logic [2:0] strobes,
                          input adt_access_pkg::addr_t push_a,
                          input adt_access_pkg::size_code_t push_s,
                          input adt_access_pkg::addr_t c0_a,
                          input adt_access_pkg::size_code_t c0_s,
                          input adt_access_pkg::addr_t c1_a,
                          input adt_access_pkg::size_code_t c1_s,
                          input logic [1:0] exp_hits);
      rows[row_cnt] = {name, strobes, push_a, push_s, c0_a, c0_s, c1_a, c1_s, exp_hits};
      row_cnt = row_cnt + 1;
   endtask

   // A push or pop in a row shows up in the compares of the next row
   task automatic load_table();
      set_row("reset_idle", 3'b000, 'h0, 3'd0, 'h100, 3'd1, 'h200, 3'd4, 2'b00);
      set_row("reset_zero", 3'b000, 'h0, 3'd0, 'h0, 3'd4, 'hFFFF_FFF0, 3'd4, 2'b00);
      set_row("push_byte_100", 3'b100, 'h100, 3'd1, 'h100, 3'd1, 'h0, 3'd1, 2'b00);
      set_row("byte_exact", 3'b000, 'h0, 3'd0, 'h100, 3'd1, 'h101, 3'd1, 2'b10);
      set_row("push_dword_200", 3'b100, 'h200, 3'd4, 'h101, 3'd2, 'h102, 3'd1, 2'b10);
      set_row("dword_coarse", 3'b000, 'h0, 3'd0, 'h205, 3'd1, 'h208, 3'd1, 2'b10);
      set_row("push_byte_307", 3'b100, 'h307, 3'd1, 'h300, 3'd4, 'h1FF, 3'd1, 2'b00);
      set_row("cmp_coarse", 3'b000, 'h0, 3'd0, 'h300, 3'd4, 'h300, 3'd1, 2'b10);
      // Misaligned word widens to an 8 byte granule
      set_row("push_word_402", 3'b100, 'h402, 3'd3, 'h100, 3'd1, 'h406, 3'd1, 2'b10);
      set_row("misalign_both", 3'b000, 'h0, 3'd0, 'h406, 3'd1, 'h40A, 3'd1, 2'b10);
      set_row("misalign_swap", 3'b000, 'h0, 3'd0, 'h40A, 3'd1, 'h400, 3'd1, 2'b01);
      set_row("full_check", 3'b000, 'h0, 3'd0, 'h100, 3'd1, 'h307, 3'd1, 2'b11);
      set_row("pop_oldest", 3'b010, 'h0, 3'd0, 'h100, 3'd1, 'h205, 3'd1, 2'b11);
      set_row("oldest_gone", 3'b000, 'h0, 3'd0, 'h100, 3'd1, 'h205, 3'd1, 2'b01);
      set_row("others_remain", 3'b000, 'h0, 3'd0, 'h307, 3'd1, 'h406, 3'd1, 2'b11);
      // Tail has wrapped, this lands in the freed slot 0
      set_row("push_wrap_500", 3'b100, 'h500, 3'd2, 'h500, 3'd1, 'h100, 3'd1, 2'b00);
      set_row("wrap_hit", 3'b000, 'h0, 3'd0, 'h501, 3'd1, 'h502, 3'd1, 2'b10);
      set_row("flush_cycle", 3'b001, 'h0, 3'd0, 'h500, 3'd1, 'h200, 3'd4, 2'b11);
      set_row("flushed_a", 3'b000, 'h0, 3'd0, 'h500, 3'd1, 'h200, 3'd4, 2'b00);
      set_row("flushed_b", 3'b000, 'h0, 3'd0, 'h307, 3'd1, 'h402, 3'd3, 2'b00);
      set_row("push_after_flush", 3'b100, 'h600, 3'd3, 'h600, 3'd1, 'h100, 3'd1, 2'b00);
      set_row("flush_reuse", 3'b000, 'h0, 3'd0, 'h603, 3'd1, 'h604, 3'd1, 2'b10);
      set_row("pop_last", 3'b010, 'h0, 3'd0, 'h600, 3'd1, 'h0, 3'd1, 2'b10);
      set_row("empty_again", 3'b000, 'h0, 3'd0, 'h600, 3'd1, 'h600, 3'd4, 2'b00);
   endtask

   task automatic apply_row(input int idx);
      {push, pop, flush} = rows[idx].strobes;
      push_addr  = rows[idx].push_addr;
      push_size  = rows[idx].push_size;
      cmp0_addr  = rows[idx].cmp0_addr;
      cmp0_size  = rows[idx].cmp0_size;
      cmp1_addr  = rows[idx].cmp1_addr;
      cmp1_size  = rows[idx].cmp1_size;
      check      = 1'b1;
      check_idx  = idx;
      check_name = rows[idx].name;
      check_exp  = rows[idx].exp_hits;
   endtask

   task automatic idle_inputs();
      {push, pop, flush} = 3'b000;
      push_addr = '0;
      push_size = '0;
      cmp0_addr = '0;
      cmp0_size = '0;
      cmp1_addr = '0;
      cmp1_size = '0;
      check     = 1'b0;
   endtask

   // Run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("run timed out after %0d cycles, only %0d of %0d rows were checked",
                  cycle_cnt, checked_cnt, num_rows);
         $display("test failed");
         $finish;
      end
   end

   initial begin
      rst_n      = 1'b0;
      check_idx  = '0;
      check_name = '0;
      check_exp  = '0;
      idle_inputs();
      load_table();
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < num_rows; i++) begin
         @(negedge clk);
         apply_row(i);
      end
      @(negedge clk);
      idle_inputs();
      if (checked_cnt != num_rows) begin
         wait (checked_cnt == num_rows);
      end
      $display("rows checked %0d, passed %0d, failed %0d",
               checked_cnt, checked_cnt - error_cnt, error_cnt);
      if (error_cnt == 0 && checked_cnt == num_rows) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/adt_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker for the address dependency table:
// samples both hits, compares, counts results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module adt_checker (
   input  wire logic          clk,
   input  wire logic          check_i,
   input  wire logic [31:0]   row_idx_i,
   input  wire logic [8*16-1:0] row_name_i,
   input  wire logic [1:0]    exp_hits_i,
   input  wire logic          hit0_i,
   input  wire logic          hit1_i,
   output int                 checked_cnt_o,
   output int                 error_cnt_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Inputs change on the falling edge, so sample just before the rising edge
   localparam int sample_delay = 45;

   initial begin
      checked_cnt_o = 0;
      error_cnt_o   = 0;
   end

   always @(negedge clk) begin
      #sample_delay;
      if (check_i) begin
         if ({hit0_i, hit1_i} !== exp_hits_i) begin
            $display("mismatch row %0d %0s: expected hits %b, actual hits %b",
                     row_idx_i, row_name_i, exp_hits_i, {hit0_i, hit1_i});
            error_cnt_o = error_cnt_o + 1;
         end else begin
            $display("row %0d %0s ok, hits %b", row_idx_i, row_name_i, {hit0_i, hit1_i});
         end
         checked_cnt_o = checked_cnt_o + 1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/address_dependency_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address dependency table top: granule decoders,
// entry queue and two alias compare ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module address_dependency_table (
   input  wire logic                       clk,
   input  wire logic                       rst_n_i,
   input  wire logic                       flush_i,
   input  wire logic                       push_i,
   input  wire logic                       pop_i,
   input  wire adt_access_pkg::addr_t      push_addr_i,
   input  wire adt_access_pkg::size_code_t push_size_i,
   input  wire adt_access_pkg::addr_t      cmp0_addr_i,
   input  wire adt_access_pkg::size_code_t cmp0_size_i,
   input  wire adt_access_pkg::addr_t      cmp1_addr_i,
   input  wire adt_access_pkg::size_code_t cmp1_size_i,
   output logic                            cmp0_hit_o,
   output logic                            cmp1_hit_o
);

   adt_access_pkg::gran_t push_gran;
   adt_access_pkg::gran_t cmp0_gran;
   adt_access_pkg::gran_t cmp1_gran;

   adt_access_pkg::dep_entry_t [adt_cfg_pkg::adt_depth-1:0] entries;

   // Granule of the store being recorded
   access_granule_decode push_dec_i (
      .addr_i (push_addr_i),
      .size_i (push_size_i),
      .gran_o (push_gran)
   );

   access_granule_decode cmp0_dec_i (
      .addr_i (cmp0_addr_i),
      .size_i (cmp0_size_i),
      .gran_o (cmp0_gran)
   );

   access_granule_decode cmp1_dec_i (
      .addr_i (cmp1_addr_i),
      .size_i (cmp1_size_i),
      .gran_o (cmp1_gran)
   );

   dep_entry_queue queue_i (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .flush_i     (flush_i),
      .push_i      (push_i),
      .pop_i       (pop_i),
      .push_addr_i (push_addr_i),
      .push_gran_i (push_gran),
      .entries_o   (entries)
   );

   alias_match_port match0_i (
      .entries_i  (entries),
      .cmp_addr_i (cmp0_addr_i),
      .cmp_gran_i (cmp0_gran),
      .hit_o      (cmp0_hit_o)
   );

   alias_match_port match1_i (
      .entries_i  (entries),
      .cmp_addr_i (cmp1_addr_i),
      .cmp_gran_i (cmp1_gran),
      .hit_o      (cmp1_hit_o)
   );

endmodule

`default_nettype wire

//--- verilog/alias_match_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One compare port: alias match of an address
// against every table entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module alias_match_port (
   input  wire adt_access_pkg::dep_entry_t [adt_cfg_pkg::adt_depth-1:0] entries_i,
   input  wire adt_access_pkg::addr_t      cmp_addr_i,
   input  wire adt_access_pkg::gran_t      cmp_gran_i,
   output logic                            hit_o
);

   logic [adt_cfg_pkg::adt_depth-1:0] entry_hit;

   // Compare above the coarser of the two granules
   function automatic logic alias_eq(
      input adt_access_pkg::dep_entry_t entry,
      input adt_access_pkg::addr_t      addr,
      input adt_access_pkg::gran_t      gran
   );
      adt_access_pkg::gran_t eff_gran;
      adt_access_pkg::addr_t keep_mask;

      if (entry.gran > gran) begin
         eff_gran = entry.gran;
      end else begin
         eff_gran = gran;
      end

      keep_mask = {adt_cfg_pkg::adt_addr_w{1'b1}} << eff_gran;
      return ((entry.addr ^ addr) & keep_mask) == '0;
   endfunction

   for (genvar i = 0; i < adt_cfg_pkg::adt_depth; i++) begin : g_entry
      // Only live entries count
      assign entry_hit[i] = entries_i[i].valid
                            & alias_eq(entries_i[i], cmp_addr_i, cmp_gran_i);
   end

   assign hit_o = |entry_hit;

endmodule

`default_nettype wire

//--- verilog/dep_entry_queue.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// In-order entry storage with head and tail
// pointers, push, pop and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module dep_entry_queue (
   input  wire logic                   clk,
   input  wire logic                   rst_n_i,
   input  wire logic                   flush_i,
   input  wire logic                   push_i,
   input  wire logic                   pop_i,
   input  wire adt_access_pkg::addr_t  push_addr_i,
   input  wire adt_access_pkg::gran_t  push_gran_i,
   output adt_access_pkg::dep_entry_t [adt_cfg_pkg::adt_depth-1:0] entries_o
);

   typedef logic [adt_cfg_pkg::adt_ptr_w-1:0] ptr_t;

   logic [adt_cfg_pkg::adt_depth-1:0] valid_q;
   ptr_t                              head_q;
   ptr_t                              tail_q;

   // Slot payload
   adt_access_pkg::addr_t addr_q [adt_cfg_pkg::adt_depth];
   adt_access_pkg::gran_t gran_q [adt_cfg_pkg::adt_depth];

   function automatic ptr_t next_ptr(input ptr_t ptr);
      ptr_t nxt;
      if (ptr == ptr_t'(adt_cfg_pkg::adt_depth - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   // Valid bits and pointers
   // Push on a full table or pop on an empty one is not supported
   always_ff @(posedge clk) begin
      if (!rst_n_i || flush_i) begin
         valid_q <= '0;
         head_q  <= '0;
         tail_q  <= '0;
      end else begin
         if (pop_i) begin
            valid_q[head_q] <= 1'b0;
            head_q          <= next_ptr(head_q);
         end
         if (push_i) begin
            valid_q[tail_q] <= 1'b1;
            tail_q          <= next_ptr(tail_q);
         end
      end
   end

   // Address and granule of the slot being filled
   always_ff @(posedge clk) begin
      if (push_i) begin
         addr_q[tail_q] <= push_addr_i;
         gran_q[tail_q] <= push_gran_i;
      end
   end

   always_comb begin
      for (int i = 0; i < adt_cfg_pkg::adt_depth; i++) begin
         entries_o[i].valid = valid_q[i];
         entries_o[i].addr  = addr_q[i];
         entries_o[i].gran  = gran_q[i];
      end
   end

endmodule

`default_nettype wire

//--- verilog/access_granule_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Size and alignment decode into an alias granule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

module access_granule_decode (
   input  wire adt_access_pkg::addr_t      addr_i,
   input  wire adt_access_pkg::size_code_t size_i,
   output adt_access_pkg::gran_t           gran_o
);

   adt_access_pkg::gran_t base_gran;
   adt_access_pkg::addr_t align_mask;
   logic                  aligned;

   // Natural granule of the access size
   always_comb begin
      case (size_i)
         adt_access_pkg::size_byte:  base_gran = 3'd0;
         adt_access_pkg::size_half:  base_gran = 3'd1;
         adt_access_pkg::size_word:  base_gran = 3'd2;
         adt_access_pkg::size_dword: base_gran = 3'd3;
         default:                    base_gran = 3'd0;
      endcase
   end

   // Low bits that must be zero for an aligned access
   assign align_mask = ~({adt_cfg_pkg::adt_addr_w{1'b1}} << base_gran);
   assign aligned    = ~|(addr_i & align_mask);

   // A misaligned access may straddle into the next granule,
   // so it aliases one step coarser
   always_comb begin
      if (aligned) begin
         gran_o = base_gran;
      end else begin
         gran_o = base_gran + 3'd1;
      end
   end

endmodule

`default_nettype wire

//--- verilog/adt_access_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Access size codes, address and granule types,
// and the table entry struct
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package adt_access_pkg;

   // Access size as seen on the push and compare ports
   typedef logic [2:0] size_code_t;

   // Codes 0 and 5..7 are reserved, treated as a byte
   localparam size_code_t size_byte  = 3'd1;
   localparam size_code_t size_half  = 3'd2;
   localparam size_code_t size_word  = 3'd3;
   localparam size_code_t size_dword = 3'd4;

   // Number of low address bits the compare ignores, 0..4
   typedef logic [adt_cfg_pkg::adt_gran_w-1:0] gran_t;

   typedef logic [adt_cfg_pkg::adt_addr_w-1:0] addr_t;

   // One table slot
   typedef struct packed {
      logic  valid;
      addr_t addr;
      gran_t gran;
   } dep_entry_t;

endpackage

`default_nettype wire

//--- verilog/adt_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Geometry constants of the address dependency
// table: depth, address, pointer and granule widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package adt_cfg_pkg;

   // Number of table entries
   localparam int adt_depth = 4;

   // Address width of pushed and compared accesses
   localparam int adt_addr_w = 32;

   // Slot index width, wraps at adt_depth
   localparam int adt_ptr_w = 2;

   // Width of the ignored-low-bits count
   localparam int adt_gran_w = 3;

   // Coarsest alias granule, 16 bytes
   localparam int adt_max_gran = 4;

endpackage

`default_nettype wire
